// File: build.f
cursor_pkg.sv
cursor_sequencer.sv
pen_walker.sv
frame_buffer.sv
palette_cursor_top.sv
tb_palette_cursor.sv

// File: cursor_pkg.sv
`default_nettype none

package cursor_pkg;

    // ************************************************************
    // widths with a meaning
    // ************************************************************

    typedef logic [5:0] coord_x_t;  // 64 columns
    typedef logic [2:0] coord_y_t;  // 8 rows
    typedef logic [2:0] slot_t;     // 8 palette slots side by side
    typedef logic [3:0] color_t;
    typedef logic [2:0] side_cnt_t; // pixels along one side

    // one pixel write into the frame buffer
    typedef struct packed {
        logic     we;
        coord_x_t x;
        coord_y_t y;
        color_t   color;
    } pixel_wr_t;

    // per-cycle request from the sequencer to the pen
    typedef struct packed {
        logic   run;      // write pen pixel, then step
        logic   axis;     // 0 = x, 1 = y
        logic   neg;      // step toward lower coordinates
        logic   side_clr;
        logic   load;     // place pen at slot origin
        color_t ink;
    } pen_cmd_t;

    // ************************************************************
    // sequencer states
    // ************************************************************

    typedef enum logic [3:0] {
        IDLE,
        GO_RIGHT,
        CLR_1,
        GO_DOWN,
        CLR_2,
        GO_LEFT,
        CLR_3,
        GO_UP,
        CLR_4,
        ERASE_DONE,
        CHANGE_INK,
        LOAD_NEW,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: cursor_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_sequencer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire cursor_pkg::slot_t    slot,
    input  wire cursor_pkg::color_t   cursor_color,
    input  wire cursor_pkg::color_t   bg_color,
    input  wire logic                 side_end,
    output cursor_pkg::pen_cmd_t      pen,
    output cursor_pkg::slot_t         load_slot,
    output logic                      busy,
    output logic                      done
);

    cursor_pkg::seq_state_t state;

    logic               pass_draw;   // 0 while erasing the old box
    logic               have_old;    // a cursor has been drawn before
    cursor_pkg::slot_t  old_slot;

    // request latched at start
    cursor_pkg::slot_t  new_slot_q;
    cursor_pkg::color_t cur_color_q;
    cursor_pkg::color_t ink_q;

    logic accept;

    assign accept = (state == cursor_pkg::IDLE) && start;

    // ************************************************************
    // state register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= cursor_pkg::IDLE;
            pass_draw <= 1'b0;
            have_old  <= 1'b0;
            old_slot  <= '0;
        end else begin
            case (state)
                cursor_pkg::IDLE: begin
                    if (start) begin
                        // no previous box means nothing to erase
                        if (have_old) begin
                            state     <= cursor_pkg::GO_RIGHT;
                            pass_draw <= 1'b0;
                        end else begin
                            state     <= cursor_pkg::LOAD_NEW;
                            pass_draw <= 1'b1;
                        end
                    end
                end
                cursor_pkg::GO_RIGHT: if (side_end) state <= cursor_pkg::CLR_1;
                cursor_pkg::CLR_1:    state <= cursor_pkg::GO_DOWN;
                cursor_pkg::GO_DOWN:  if (side_end) state <= cursor_pkg::CLR_2;
                cursor_pkg::CLR_2:    state <= cursor_pkg::GO_LEFT;
                cursor_pkg::GO_LEFT:  if (side_end) state <= cursor_pkg::CLR_3;
                cursor_pkg::CLR_3:    state <= cursor_pkg::GO_UP;
                cursor_pkg::GO_UP:    if (side_end) state <= cursor_pkg::CLR_4;
                cursor_pkg::CLR_4: begin
                    state <= pass_draw ? cursor_pkg::DONE : cursor_pkg::ERASE_DONE;
                end
                cursor_pkg::ERASE_DONE: state <= cursor_pkg::CHANGE_INK;
                cursor_pkg::CHANGE_INK: state <= cursor_pkg::LOAD_NEW;
                cursor_pkg::LOAD_NEW: begin
                    state     <= cursor_pkg::GO_RIGHT;
                    pass_draw <= 1'b1;
                end
                cursor_pkg::DONE: begin
                    state    <= cursor_pkg::IDLE;
                    old_slot <= new_slot_q; // new box becomes the one to erase
                    have_old <= 1'b1;
                end
                default: state <= cursor_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            new_slot_q  <= slot;
            cur_color_q <= cursor_color;
            ink_q       <= have_old ? bg_color : cursor_color;
        end else if (state == cursor_pkg::CHANGE_INK) begin
            ink_q <= cur_color_q;
        end
    end

    // ************************************************************
    // output decode
    // ************************************************************

    always_comb begin
        pen.run      = 1'b0;
        pen.axis     = 1'b0;
        pen.neg      = 1'b0;
        pen.side_clr = 1'b0;
        pen.load     = 1'b0;
        pen.ink      = ink_q;
        load_slot    = old_slot;
        done         = 1'b0;
        case (state)
            cursor_pkg::IDLE: begin
                pen.load     = 1'b1; // park the pen on the old box
                pen.side_clr = 1'b1;
            end
            cursor_pkg::GO_RIGHT: begin
                pen.run = ~side_end;
            end
            cursor_pkg::GO_DOWN: begin
                pen.run  = ~side_end;
                pen.axis = 1'b1;
            end
            cursor_pkg::GO_LEFT: begin
                pen.run = ~side_end;
                pen.neg = 1'b1;
            end
            cursor_pkg::GO_UP: begin
                pen.run  = ~side_end;
                pen.axis = 1'b1;
                pen.neg  = 1'b1;
            end
            cursor_pkg::CLR_1, cursor_pkg::CLR_2,
            cursor_pkg::CLR_3, cursor_pkg::CLR_4: begin
                pen.side_clr = 1'b1;
            end
            cursor_pkg::LOAD_NEW: begin
                pen.load     = 1'b1;
                pen.side_clr = 1'b1;
                load_slot    = new_slot_q;
            end
            cursor_pkg::DONE: begin
                done = 1'b1;
            end
            default: begin
                // ERASE_DONE and CHANGE_INK drive no pen activity
            end
        endcase
    end

    assign busy = (state != cursor_pkg::IDLE);

endmodule

`default_nettype wire

// File: frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int CELL_W    = 8,
    parameter int NUM_SLOTS = 8
) (
    input  wire logic                  clk,
    input  wire cursor_pkg::pixel_wr_t wr,
    input  wire cursor_pkg::coord_x_t  rd_x,
    input  wire cursor_pkg::coord_y_t  rd_y,
    output cursor_pkg::color_t         rd_color
);

    localparam int FB_W  = CELL_W * NUM_SLOTS;
    localparam int FB_H  = 2 ** $bits(cursor_pkg::coord_y_t);
    localparam int DEPTH = FB_W * FB_H;
    localparam int AW    = $clog2(DEPTH);

    cursor_pkg::color_t mem [DEPTH];

    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    // row major
    assign wr_addr = AW'(int'(wr.y) * FB_W + int'(wr.x));
    assign rd_addr = AW'(int'(rd_y) * FB_W + int'(rd_x));

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.color;
        end
    end

    always_ff @(posedge clk) begin
        rd_color <= mem[rd_addr]; // old data on a same-address write
    end

endmodule

`default_nettype wire

// File: palette_cursor_top.sv
`timescale 1ns/1ps
`default_nettype none

module palette_cursor_top #(
    parameter int CELL_W    = 8,   // box side, at most 8
    parameter int NUM_SLOTS = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire cursor_pkg::slot_t    slot,
    input  wire cursor_pkg::color_t   cursor_color,
    input  wire cursor_pkg::color_t   bg_color,
    input  wire cursor_pkg::coord_x_t rd_x,
    input  wire cursor_pkg::coord_y_t rd_y,
    output cursor_pkg::color_t        rd_color,
    output logic                      busy,
    output logic                      done
);

    cursor_pkg::pen_cmd_t  pen;
    cursor_pkg::slot_t     load_slot;
    cursor_pkg::pixel_wr_t wr;
    logic                  side_end;

    // ************************************************************
    // erase / draw ordering
    // ************************************************************

    cursor_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .slot         (slot),
        .cursor_color (cursor_color),
        .bg_color     (bg_color),
        .side_end     (side_end),
        .pen          (pen),
        .load_slot    (load_slot),
        .busy         (busy),
        .done         (done)
    );

    pen_walker #(
        .CELL_W (CELL_W)
    ) u_pen (
        .clk       (clk),
        .rst       (rst),
        .pen       (pen),
        .load_slot (load_slot),
        .side_end  (side_end),
        .wr        (wr)
    );

    // ************************************************************
    // pixel store
    // ************************************************************

    frame_buffer #(
        .CELL_W    (CELL_W),
        .NUM_SLOTS (NUM_SLOTS)
    ) u_fb (
        .clk      (clk),
        .wr       (wr),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_color (rd_color)
    );

endmodule

`default_nettype wire

// File: pen_walker.sv
`timescale 1ns/1ps
`default_nettype none

module pen_walker #(
    parameter int CELL_W = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cursor_pkg::pen_cmd_t pen,
    input  wire cursor_pkg::slot_t    load_slot,
    output logic                      side_end,
    output cursor_pkg::pixel_wr_t     wr
);

    localparam cursor_pkg::side_cnt_t LAST = cursor_pkg::side_cnt_t'(CELL_W - 1);

    cursor_pkg::coord_x_t  x_q;
    cursor_pkg::coord_y_t  y_q;
    cursor_pkg::side_cnt_t cnt;

    cursor_pkg::coord_x_t  origin_x;
    cursor_pkg::coord_x_t  x_step;
    cursor_pkg::coord_y_t  y_step;

    // ************************************************************
    // slot to origin, next positions
    // ************************************************************

    assign origin_x = cursor_pkg::coord_x_t'(int'(load_slot) * CELL_W); // y origin is row 0

    always_comb begin
        x_step = x_q;
        y_step = y_q;
        if (!pen.axis) begin
            x_step = pen.neg ? x_q - 1'b1 : x_q + 1'b1;
        end else begin
            y_step = pen.neg ? y_q - 1'b1 : y_q + 1'b1;
        end
    end

    // ************************************************************
    // position and side counter
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (pen.load) begin
            x_q <= origin_x;
            y_q <= '0;
        end else if (pen.run) begin
            x_q <= x_step;
            y_q <= y_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (pen.side_clr) begin
            cnt <= '0;
        end else if (pen.run) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign side_end = (cnt == LAST); // CELL_W-1 pixels per side

    // write the current pen position before it moves
    always_comb begin
        wr.we    = pen.run;
        wr.x     = x_q;
        wr.y     = y_q;
        wr.color = pen.ink;
    end

endmodule

`default_nettype wire

// File: tb_palette_cursor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_palette_cursor;

    localparam int CELL_W      = 8;
    localparam int NUM_SLOTS   = 8;
    localparam int NUM_MOVES   = 24;     // moves in all directed tests
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = NUM_MOVES * (2 * 4 * CELL_W + 20) * CLK_NS * 4;

    logic                 clk;
    logic                 rst;
    logic                 start;
    cursor_pkg::slot_t    slot;
    cursor_pkg::color_t   cursor_color;
    cursor_pkg::color_t   bg_color;
    cursor_pkg::coord_x_t rd_x;
    cursor_pkg::coord_y_t rd_y;
    cursor_pkg::color_t   rd_color;
    logic                 busy;
    logic                 done;

    cursor_pkg::slot_t    marked;       // slot the model believes is outlined

    palette_cursor_top #(
        .CELL_W    (CELL_W),
        .NUM_SLOTS (NUM_SLOTS)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .slot         (slot),
        .cursor_color (cursor_color),
        .bg_color     (bg_color),
        .rd_x         (rd_x),
        .rd_y         (rd_y),
        .rd_color     (rd_color),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ************************************************************
    // helpers
    // ************************************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic pulse_start(input cursor_pkg::slot_t s, input cursor_pkg::color_t cc,
                               input cursor_pkg::color_t bg);
        @(posedge clk);
        start        <= 1'b1;
        slot         <= s;
        cursor_color <= cc;
        bg_color     <= bg;
        @(posedge clk);
        start        <= 1'b0;
    endtask

    // done must be a single cycle, with busy still high in that cycle
    task automatic wait_done();
        while (done !== 1'b1) @(negedge clk);   // watchdog bounds this loop
        check_value("busy", busy, 1'b1);
        @(negedge clk);
        check_value("done", done, 1'b0);
        check_value("busy", busy, 1'b0);
    endtask

    task automatic move_cursor(input cursor_pkg::slot_t s, input cursor_pkg::color_t cc,
                               input cursor_pkg::color_t bg);
        pulse_start(s, cc, bg);
        @(negedge clk);
        check_value("busy", busy, 1'b1);
        wait_done();
        marked = s;
    endtask

    task automatic read_pixel(input int x, input int y, output cursor_pkg::color_t c);
        @(posedge clk);
        rd_x <= cursor_pkg::coord_x_t'(x);
        rd_y <= cursor_pkg::coord_y_t'(y);
        @(posedge clk);                       // read data registered here
        @(negedge clk);
        c = rd_color;
    endtask

    // box border around the slot, origin at x = slot * CELL_W, y = 0
    task automatic check_outline(input cursor_pkg::slot_t s, input cursor_pkg::color_t color);
        int                 x0;
        cursor_pkg::color_t got;
        x0 = int'(s) * CELL_W;
        for (int y = 0; y < CELL_W; y++) begin
            for (int x = x0; x < x0 + CELL_W; x++) begin
                if (y == 0 || y == CELL_W - 1 || x == x0 || x == x0 + CELL_W - 1) begin
                    read_pixel(x, y, got);
                    check_value($sformatf("rd_color(%0d,%0d)", x, y), got, color);
                end
            end
        end
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************

    task automatic first_move();
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
        move_cursor(3'd2, 4'ha, 4'h1);    // nothing to erase yet
        check_outline(3'd2, 4'ha);
    endtask

    task automatic move_erases_old();
        move_cursor(3'd5, 4'ha, 4'h3);
        check_outline(3'd2, 4'h3);
        check_outline(3'd5, 4'ha);
    endtask

    task automatic busy_start_ignored();
        pulse_start(3'd1, 4'h6, 4'h2);
        repeat (4) @(posedge clk);
        pulse_start(3'd2, 4'hf, 4'he);    // arrives mid erase pass
        @(negedge clk);
        wait_done();
        marked = 3'd1;
        repeat (4) begin
            @(negedge clk);
            check_value("busy", busy, 1'b0);
        end
        check_outline(3'd1, 4'h6);
        check_outline(3'd5, 4'h2);
        check_outline(3'd2, 4'h3);        // untouched by the ignored request
    endtask

    task automatic recolor_same_slot();
        move_cursor(marked, 4'hc, 4'h2);
        check_outline(3'd1, 4'hc);
    endtask

    task automatic random_moves();
        cursor_pkg::slot_t  prev;
        cursor_pkg::slot_t  s;
        cursor_pkg::color_t cc;
        cursor_pkg::color_t bg;
        repeat (20) begin
            prev = marked;
            s    = cursor_pkg::slot_t'($urandom % NUM_SLOTS);
            cc   = cursor_pkg::color_t'($urandom);
            bg   = cursor_pkg::color_t'($urandom);
            move_cursor(s, cc, bg);
            check_outline(s, cc);
            if (prev != s) begin
                check_outline(prev, bg);  // same slot shares every pixel
            end
        end
    endtask

    // ************************************************************
    // main sequence and watchdog
    // ************************************************************

    initial begin
        void'($urandom(32'h7a35_2df2));
        marked       = '0;
        rst          = 1'b1;
        start        = 1'b0;
        slot         = '0;
        cursor_color = '0;
        bg_color     = '0;
        rd_x         = '0;
        rd_y         = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        first_move();
        move_erases_old();
        busy_start_ignored();
        recolor_same_slot();
        random_moves();

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: done never came within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
